//--- Bender.yml
package:
  name: uart_main_ctrl

export_include_dirs:
  - .

sources:
  - uart_ctrl_pkg.sv
  - uart_cfg_regs.sv
  - uart_cfg_master.sv
  - uart_rx_error.sv
  - uart_main_ctrl.sv
  - target: simulation
    files:
      - uart_main_ctrl_tb.sv

//--- uart_cfg_master.sv
// ----------------------------------------------------------
// Master configuration FSM: SYN request, ACK waits, packets
// Transmitter is assumed to always accept, no back-pressure
// tx_done_i is a one-cycle pulse when the TX queue drains
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "uart_ctrl_config.svh"

module uart_cfg_master import uart_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cfg_wr_i,
  input  logic       std_cfg_i,
  input  logic       cfg_req_i,
  input  logic       tx_done_i,
  input  logic       rx_empty_i,
  input  uart_byte_t rx_data_i,
  input  uart_byte_t cfg_pkt_i,
  output logic       cfg_wr_en_o,
  output logic       std_load_o,
  output logic       tx_wr_o,
  output logic       rx_rd_o,
  output logic       cfg_done_o,
  output logic       stream_mode_o,
  output logic       cfg_fail_o,
  output cfg_id_e    pkt_sel_o,
  output uart_byte_t tx_data_o
);

  localparam int TO_W  = $clog2(`UART_ACK_TIMEOUT + 1);
  localparam int SYN_W = $clog2(`UART_SYN_COUNT + 1);
  localparam int RTY_W = $clog2(`UART_CFG_RETRIES + 1);

  cfg_state_e       state_q, state_d;
  logic [TO_W-1:0]  timeout_cnt;
  logic [SYN_W-1:0] syn_cnt;
  logic [RTY_W-1:0] retry_cnt;
  logic             ack_wait;
  logic             ack_seen;
  logic             timeout;
  logic             last_syn;
  logic             last_retry;

  // ----------------------------------------------------------
  // Counters
  // ----------------------------------------------------------

  assign ack_wait   = (state_q == ST_WAIT_REQ_ACK) || (state_q == ST_WAIT_PKT_ACK);
  // Any head byte is popped, only ACK counts
  assign ack_seen   = ack_wait && !rx_empty_i && (rx_data_i == `UART_ACK_BYTE);
  assign timeout    = ack_wait && (timeout_cnt == TO_W'(`UART_ACK_TIMEOUT - 1));
  assign last_syn   = (syn_cnt == SYN_W'(`UART_SYN_COUNT - 1));
  assign last_retry = (retry_cnt == RTY_W'(`UART_CFG_RETRIES - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      timeout_cnt <= '0;
      syn_cnt     <= '0;
      retry_cnt   <= '0;
      pkt_sel_o   <= ID_DATA_WIDTH;
    end else begin
      // Timeout runs only inside a wait, so it restarts on every entry
      timeout_cnt <= ack_wait ? timeout_cnt + 1'b1 : '0;
      syn_cnt     <= (state_q == ST_SEND_SYN) ? syn_cnt + 1'b1 : '0;
      if (state_q == ST_MAIN) begin
        retry_cnt <= '0;
        pkt_sel_o <= ID_DATA_WIDTH;
      end else if (state_q == ST_WAIT_REQ_ACK && timeout && !ack_seen) begin
        retry_cnt <= retry_cnt + 1'b1;
      end else if (state_q == ST_WAIT_PKT_ACK && ack_seen && pkt_sel_o != ID_END) begin
        // Step to the next packet type
        pkt_sel_o <= cfg_id_e'(pkt_sel_o + 2'd1);
      end
    end
  end

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    cfg_fail_o = 1'b0;
    case (state_q)
      ST_RESET: state_d = ST_MAIN;
      ST_MAIN: begin
        // Request has priority over a standard load
        if (cfg_req_i) begin
          state_d = ST_SEND_SYN;
        end else if (std_cfg_i) begin
          state_d = ST_STD_CFG;
        end
      end
      ST_STD_CFG: state_d = ST_MAIN;
      ST_SEND_SYN: begin
        if (last_syn) begin
          state_d = ST_WAIT_SYN_TX;
        end
      end
      ST_WAIT_SYN_TX: begin
        if (tx_done_i) begin
          state_d = ST_WAIT_REQ_ACK;
        end
      end
      ST_WAIT_REQ_ACK: begin
        if (ack_seen) begin
          state_d = ST_SEND_PKT;
        end else if (timeout) begin
          // Retry with fresh SYNs until attempts run out
          if (last_retry) begin
            cfg_fail_o = 1'b1;
            state_d    = ST_STD_CFG;
          end else begin
            state_d = ST_SEND_SYN;
          end
        end
      end
      ST_SEND_PKT: state_d = ST_WAIT_PKT_TX;
      ST_WAIT_PKT_TX: begin
        if (tx_done_i) begin
          state_d = ST_WAIT_PKT_ACK;
        end
      end
      ST_WAIT_PKT_ACK: begin
        if (ack_seen) begin
          state_d = (pkt_sel_o == ID_END) ? ST_MAIN : ST_SEND_PKT;
        end else if (timeout) begin
          // No retry in the packet phase
          cfg_fail_o = 1'b1;
          state_d    = ST_STD_CFG;
        end
      end
      default: state_d = ST_RESET;
    endcase
  end

  // Outputs decoded from the current state
  assign cfg_wr_en_o   = cfg_wr_i && (state_q == ST_MAIN);
  assign std_load_o    = (state_q == ST_STD_CFG);
  assign cfg_done_o    = (state_q == ST_MAIN);
  assign stream_mode_o = (state_q inside {ST_SEND_SYN, ST_WAIT_SYN_TX, ST_WAIT_REQ_ACK,
                                          ST_SEND_PKT, ST_WAIT_PKT_TX, ST_WAIT_PKT_ACK});
  assign tx_wr_o       = (state_q == ST_SEND_SYN) || (state_q == ST_SEND_PKT);
  assign tx_data_o     = (state_q == ST_SEND_PKT) ? cfg_pkt_i : `UART_SYN_BYTE;
  assign rx_rd_o       = ack_wait && !rx_empty_i;

  // Pops only happen on a non-empty FIFO
  assert property (@(posedge clk_i) disable iff (!rst_n_i) rx_rd_o |-> !rx_empty_i)
    else $error("RX pop while FIFO empty");

  // First cycle out of reset is quiet
  assert property (@(posedge clk_i) !rst_n_i |=> !tx_wr_o)
    else $error("TX write right after reset");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(cfg_done_o && stream_mode_o))
    else $error("Done and stream mode both high");

endmodule : uart_cfg_master

//--- uart_cfg_regs.sv
// ----------------------------------------------------------
// Active frame settings and outgoing packet assembly
// CPU write and standard load must not arrive together
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "uart_ctrl_config.svh"

module uart_cfg_regs import uart_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cfg_wr_en_i,
  input  logic       std_load_i,
  input  cfg_field_t data_width_i,
  input  cfg_field_t parity_i,
  input  cfg_field_t stop_bits_i,
  input  cfg_id_e    pkt_sel_i,
  output cfg_field_t data_width_o,
  output cfg_field_t parity_o,
  output cfg_field_t stop_bits_o,
  output uart_byte_t cfg_pkt_o
);

  // Setting registers, standard frame out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_width_o <= `UART_STD_DATA_WIDTH;
      parity_o     <= `UART_STD_PARITY;
      stop_bits_o  <= `UART_STD_STOP_BITS;
    end else if (std_load_i) begin
      data_width_o <= `UART_STD_DATA_WIDTH;
      parity_o     <= `UART_STD_PARITY;
      stop_bits_o  <= `UART_STD_STOP_BITS;
    end else if (cfg_wr_en_i) begin
      data_width_o <= data_width_i;
      parity_o     <= parity_i;
      stop_bits_o  <= stop_bits_i;
    end
  end

  // Packet for the selected id, end packet carries option 00
  always_comb begin
    cfg_field_t option;
    case (pkt_sel_i)
      ID_DATA_WIDTH: option = data_width_o;
      ID_PARITY:     option = parity_o;
      ID_STOP_BITS:  option = stop_bits_o;
      default:       option = 2'b00;
    endcase
    // Upper nibble stays zero so a packet never looks like ACK
    cfg_pkt_o = {4'b0000, pkt_sel_i, option};
  end

  // Write is only taken in the main state, load only in the std state
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(cfg_wr_en_i && std_load_i))
    else $error("CPU write and standard load in the same cycle");

endmodule : uart_cfg_regs

//--- uart_ctrl_config.svh
// ----------------------------------------------------------
// Controller constants shared by the configuration blocks
// ACK timeout is shortened for simulation (50 ms in silicon)
// ----------------------------------------------------------

`ifndef UART_CTRL_CONFIG_SVH
`define UART_CTRL_CONFIG_SVH

// Cycles in an acknowledge wait before giving up
`define UART_ACK_TIMEOUT 200
// Request attempts before the configuration fails
`define UART_CFG_RETRIES 3
// SYN characters sent per request
`define UART_SYN_COUNT 3

// Special line characters
`define UART_SYN_BYTE 8'h16
`define UART_ACK_BYTE 8'hFF

// Standard frame: 8 data bits, no parity, one stop bit
`define UART_STD_DATA_WIDTH 2'b11
`define UART_STD_PARITY 2'b00
`define UART_STD_STOP_BITS 2'b00

`endif

//--- uart_ctrl_pkg.sv
// ----------------------------------------------------------
// Types shared by the UART configuration controller
// Packet byte layout is {4'b0000, id[1:0], option[1:0]}
// ----------------------------------------------------------

package uart_ctrl_pkg;

  // Line data, one character
  typedef logic [7:0] uart_byte_t;

  // Setting code
  // Data width 00..11 = 5..8 bits
  // Parity 00 none, 01 even, 10 odd, 11 none
  // Stop bits 00 one, 01 two
  typedef logic [1:0] cfg_field_t;

  // Packet id, listed in send order
  typedef enum logic [1:0] {
    ID_DATA_WIDTH = 2'd0,
    ID_PARITY     = 2'd1,
    ID_STOP_BITS  = 2'd2,
    ID_END        = 2'd3
  } cfg_id_e;

  // Configuration FSM states, nine of them so 4 bits
  typedef enum logic [3:0] {
    ST_RESET,
    ST_MAIN,
    ST_STD_CFG,
    ST_SEND_SYN,
    ST_WAIT_SYN_TX,
    ST_WAIT_REQ_ACK,
    ST_SEND_PKT,
    ST_WAIT_PKT_TX,
    ST_WAIT_PKT_ACK
  } cfg_state_e;

endpackage : uart_ctrl_pkg

//--- uart_main_ctrl.f
+incdir+.
uart_ctrl_pkg.sv
uart_cfg_regs.sv
uart_cfg_master.sv
uart_rx_error.sv
uart_main_ctrl.sv
uart_main_ctrl_tb.sv

//--- uart_main_ctrl.sv
// ----------------------------------------------------------
// UART master-side configuration controller, top level
// Transmitter must always accept a write, no back-pressure
// Slave side answering is not supported
// ----------------------------------------------------------

`timescale 1ns/1ps

module uart_main_ctrl import uart_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // CPU side
  input  logic       cfg_wr_i,
  input  cfg_field_t cfg_data_width_i,
  input  cfg_field_t cfg_parity_i,
  input  cfg_field_t cfg_stop_bits_i,
  input  logic       std_cfg_i,
  input  logic       cfg_req_i,
  input  logic       irq_ack_i,
  output cfg_field_t cfg_data_width_o,
  output cfg_field_t cfg_parity_o,
  output cfg_field_t cfg_stop_bits_o,
  output logic       cfg_done_o,
  output logic       stream_mode_o,
  // Transmit side
  output logic       tx_wr_o,
  output uart_byte_t tx_data_o,
  input  logic       tx_done_i,
  // Receive side
  input  logic       rx_empty_i,
  input  uart_byte_t rx_data_i,
  input  logic       rx_parity_i,
  input  logic       frame_error_i,
  input  logic       overrun_error_i,
  output logic       rx_rd_o,
  // Error flags
  output logic       parity_error_o,
  output logic       frame_error_o,
  output logic       overrun_error_o,
  output logic       config_error_o
);

  logic       cfg_wr_en;
  logic       std_load;
  logic       cfg_fail;
  cfg_id_e    pkt_sel;
  uart_byte_t cfg_pkt;

  // Setting registers and packet builder
  uart_cfg_regs uart_cfg_regs_i (
    .clk_i, .rst_n_i,
    .cfg_wr_en_i (cfg_wr_en),        .std_load_i  (std_load),
    .data_width_i(cfg_data_width_i), .parity_i    (cfg_parity_i),
    .stop_bits_i (cfg_stop_bits_i),  .pkt_sel_i   (pkt_sel),
    .data_width_o(cfg_data_width_o), .parity_o    (cfg_parity_o),
    .stop_bits_o (cfg_stop_bits_o),  .cfg_pkt_o   (cfg_pkt)
  );

  // Sequencer for request, ACK and packet exchange
  uart_cfg_master uart_cfg_master_i (
    .clk_i, .rst_n_i, .cfg_wr_i, .std_cfg_i, .cfg_req_i, .tx_done_i, .rx_empty_i,
    .rx_data_i, .cfg_pkt_i(cfg_pkt), .cfg_wr_en_o(cfg_wr_en), .std_load_o(std_load),
    .tx_wr_o, .rx_rd_o, .cfg_done_o, .stream_mode_o, .cfg_fail_o(cfg_fail),
    .pkt_sel_o(pkt_sel), .tx_data_o
  );

  // Receive errors against the active settings
  uart_rx_error uart_rx_error_i (
    .clk_i, .rst_n_i, .rx_empty_i, .rx_parity_i, .frame_error_i, .overrun_error_i,
    .cfg_fail_i(cfg_fail), .irq_ack_i, .rx_data_i,
    .data_width_i(cfg_data_width_o), .parity_i(cfg_parity_o),
    .parity_error_o, .frame_error_o, .overrun_error_o, .config_error_o
  );

endmodule : uart_main_ctrl

//--- uart_main_ctrl_tb.sv
// ----------------------------------------------------------
// Directed testbench for the UART configuration controller
// TX model pulses tx_done_i a few cycles after the last write
// RX model feeds a byte queue through a one-deep FIFO head
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "uart_ctrl_config.svh"

module uart_main_ctrl_tb import uart_ctrl_pkg::*; ();

  logic       clk_i;
  logic       rst_n_i;
  logic       cfg_wr_i;
  cfg_field_t cfg_data_width_i;
  cfg_field_t cfg_parity_i;
  cfg_field_t cfg_stop_bits_i;
  logic       std_cfg_i;
  logic       cfg_req_i;
  logic       irq_ack_i;
  logic       tx_done_i;
  logic       rx_empty_i;
  uart_byte_t rx_data_i;
  logic       rx_parity_i;
  logic       frame_error_i;
  logic       overrun_error_i;
  cfg_field_t cfg_data_width_o, cfg_parity_o, cfg_stop_bits_o;
  logic       cfg_done_o, stream_mode_o, tx_wr_o, rx_rd_o;
  uart_byte_t tx_data_o;
  logic       parity_error_o, frame_error_o, overrun_error_o, config_error_o;

  uart_byte_t tx_log[$];
  uart_byte_t rx_q[$];
  int         drain_cnt;
  logic       done_pending;
  logic       pop_seen;
  int         n_checks;
  int         n_errors;
  int         n_timeouts;

  uart_main_ctrl uart_main_ctrl_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Line models
  // ----------------------------------------------------------

  // Rising edge sample of the DUT logs TX bytes and notes pops
  always @(posedge clk_i) begin
    if (tx_wr_o) begin
      tx_log.push_back(tx_data_o);
      drain_cnt = 3;
    end else if (drain_cnt > 0) begin
      drain_cnt = drain_cnt - 1;
      done_pending = (drain_cnt == 0);
    end
    pop_seen = rx_rd_o;
  end

  // Drive side of both models 2 ns after the edge
  always @(posedge clk_i) begin
    #2;
    tx_done_i = done_pending;
    done_pending = 1'b0;
    if (pop_seen) begin
      rx_empty_i = 1'b1;
      pop_seen = 1'b0;
    end
    // Next queued byte becomes the FIFO head
    if (rx_empty_i && rx_q.size() > 0) begin
      rx_data_i = rx_q.pop_front();
      rx_empty_i = 1'b0;
    end
  end

  // ----------------------------------------------------------
  // Compare and wait helpers
  // ----------------------------------------------------------

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_field(input string name, input cfg_field_t got, input cfg_field_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_settings(input cfg_field_t w, input cfg_field_t p, input cfg_field_t s);
    check_field("cfg_data_width_o", cfg_data_width_o, w);
    check_field("cfg_parity_o", cfg_parity_o, p);
    check_field("cfg_stop_bits_o", cfg_stop_bits_o, s);
  endtask

  task automatic check_standard();
    check_settings(`UART_STD_DATA_WIDTH, `UART_STD_PARITY, `UART_STD_STOP_BITS);
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  // Waits end on a falling edge
  task automatic wait_log(input int count, input int limit);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (tx_log.size() < count && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
    end
    if (tx_log.size() < count) begin
      n_timeouts++;
      $display("Timeout: TX log holds %0d bytes, %0d expected", tx_log.size(), count);
    end
  endtask

  task automatic wait_done(input int limit);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (!cfg_done_o && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!cfg_done_o) begin
      n_timeouts++;
      $display("Timeout: controller never returned to the main state at %0t", $time);
    end
  endtask

  task automatic wait_cfg_error(input int limit);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (!config_error_o && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!config_error_o) begin
      n_timeouts++;
      $display("Timeout: configuration error never raised at %0t", $time);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------

  task automatic cpu_write(input cfg_field_t w, input cfg_field_t p, input cfg_field_t s);
    step();
    cfg_wr_i = 1'b1;
    cfg_data_width_i = w;
    cfg_parity_i = p;
    cfg_stop_bits_i = s;
    step();
    cfg_wr_i = 1'b0;
  endtask

  task automatic std_strobe();
    step();
    std_cfg_i = 1'b1;
    step();
    std_cfg_i = 1'b0;
  endtask

  task automatic start_request();
    step();
    cfg_req_i = 1'b1;
    step();
    cfg_req_i = 1'b0;
  endtask

  task automatic clear_cfg_error();
    step();
    irq_ack_i = 1'b1;
    step();
    irq_ack_i = 1'b0;
    @(negedge clk_i);
    check_flag("config_error_o", config_error_o, 1'b0);
  endtask

  // Random bytes that are never ACK
  task automatic push_junk(input int n);
    uart_byte_t b;
    repeat (n) begin
      b = uart_byte_t'($urandom);
      if (b == `UART_ACK_BYTE) begin
        b = 8'h00;
      end
      rx_q.push_back(b);
    end
  endtask

  task automatic check_syn(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      check_byte("tx_data_o", tx_log[i], `UART_SYN_BYTE);
    end
  endtask

  // Packet is {0000, id, option} and the end packet carries option 00
  task automatic ack_packets(input cfg_field_t w, input cfg_field_t p, input cfg_field_t s,
                             input int junk);
    cfg_field_t opt;
    for (int id = 0; id < 4; id++) begin
      opt = (id == 0) ? w : (id == 1) ? p : (id == 2) ? s : 2'b00;
      wait_log(4 + id, 40);
      check_byte("tx_data_o", tx_log[3 + id], {4'b0000, 2'(id), opt});
      check_flag("stream_mode_o", stream_mode_o, 1'b1);
      push_junk(junk);
      rx_q.push_back(`UART_ACK_BYTE);
    end
  endtask

  task automatic parity_case(input cfg_field_t w, input cfg_field_t p);
    uart_byte_t d;
    logic       x;
    logic       bit_in;
    logic       exp;
    cpu_write(w, p, 2'b00);
    repeat (4) begin
      d = uart_byte_t'($urandom);
      bit_in = 1'($urandom);
      x = 1'b0;
      for (int i = 0; i < 5 + w; i++) begin
        x ^= d[i];
      end
      // Even parity wants the XOR and odd its inverse
      exp = (p == 2'b01) ? (bit_in != x) : (p == 2'b10) ? (bit_in == x) : 1'b0;
      step();
      rx_data_i = d;
      rx_parity_i = bit_in;
      rx_empty_i = 1'b0;
      @(negedge clk_i);
      check_flag("parity_error_o", parity_error_o, exp);
    end
    step();
    rx_empty_i = 1'b1;
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------

  task automatic reset_state();
    @(negedge clk_i);
    check_standard();
    check_flag("tx_wr_o", tx_wr_o, 1'b0);
    check_flag("rx_rd_o", rx_rd_o, 1'b0);
    check_flag("stream_mode_o", stream_mode_o, 1'b0);
    check_flag("config_error_o", config_error_o, 1'b0);
    wait_done(10);
  endtask

  task automatic cpu_write_and_rx_errors();
    cpu_write(2'b10, 2'b01, 2'b01);
    @(negedge clk_i);
    check_settings(2'b10, 2'b01, 2'b01);
    std_strobe();
    @(negedge clk_i);
    check_flag("cfg_done_o", cfg_done_o, 1'b0);
    check_settings(2'b10, 2'b01, 2'b01);
    step();
    @(negedge clk_i);
    check_standard();
    check_flag("cfg_done_o", cfg_done_o, 1'b1);
    for (int w = 0; w < 4; w++) begin
      parity_case(2'(w), 2'b10);
    end
    parity_case(2'b01, 2'b01);
    parity_case(2'b11, 2'b00);
    // Frame and overrun are plain pass-through
    step();
    frame_error_i = 1'b1;
    @(negedge clk_i);
    check_flag("frame_error_o", frame_error_o, 1'b1);
    check_flag("overrun_error_o", overrun_error_o, 1'b0);
    step();
    frame_error_i = 1'b0;
    overrun_error_i = 1'b1;
    @(negedge clk_i);
    check_flag("frame_error_o", frame_error_o, 1'b0);
    check_flag("overrun_error_o", overrun_error_o, 1'b1);
    step();
    overrun_error_i = 1'b0;
    std_strobe();
    wait_done(10);
  endtask

  task automatic full_config(input int junk);
    tx_log.delete();
    cpu_write(2'b01, 2'b10, 2'b01);
    start_request();
    wait_log(3, 20);
    check_syn(0, 3);
    check_flag("stream_mode_o", stream_mode_o, 1'b1);
    // Junk ahead of each ACK must be popped and dropped
    push_junk(junk);
    rx_q.push_back(`UART_ACK_BYTE);
    ack_packets(2'b01, 2'b10, 2'b01, junk);
    wait_done(300);
    check_settings(2'b01, 2'b10, 2'b01);
    check_flag("config_error_o", config_error_o, 1'b0);
    check_flag("tx log holds 7 bytes", tx_log.size() == 7, 1'b1);
    check_flag("rx queue drained", rx_q.size() == 0 && rx_empty_i, 1'b1);
  endtask

  task automatic packet_timeout();
    tx_log.delete();
    cpu_write(2'b00, 2'b01, 2'b01);
    start_request();
    wait_log(3, 20);
    rx_q.push_back(`UART_ACK_BYTE);
    wait_log(4, 40);
    check_byte("tx_data_o", tx_log[3], 8'h00);
    wait_cfg_error(`UART_ACK_TIMEOUT + 20);
    wait_done(10);
    check_standard();
    check_flag("tx log holds 4 bytes", tx_log.size() == 4, 1'b1);
    clear_cfg_error();
  endtask

  task automatic request_retries();
    tx_log.delete();
    cpu_write(2'b10, 2'b10, 2'b01);
    start_request();
    wait_cfg_error(`UART_CFG_RETRIES * (`UART_ACK_TIMEOUT + 20));
    check_flag("tx log holds 9 bytes", tx_log.size() == 9, 1'b1);
    check_syn(0, 9);
    wait_done(10);
    check_standard();
    clear_cfg_error();
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    void'($urandom(32'h22eb_cb4b));
    n_checks = 0;
    n_errors = 0;
    n_timeouts = 0;
    drain_cnt = 0;
    done_pending = 1'b0;
    pop_seen = 1'b0;
    rst_n_i = 1'b0;
    cfg_wr_i = 1'b0;
    cfg_data_width_i = 2'b00;
    cfg_parity_i = 2'b00;
    cfg_stop_bits_i = 2'b00;
    std_cfg_i = 1'b0;
    cfg_req_i = 1'b0;
    irq_ack_i = 1'b0;
    tx_done_i = 1'b0;
    rx_empty_i = 1'b1;
    rx_data_i = 8'h00;
    rx_parity_i = 1'b0;
    frame_error_i = 1'b0;
    overrun_error_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    reset_state();
    cpu_write_and_rx_errors();
    full_config(0);
    packet_timeout();
    request_retries();
    full_config(2);
    $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : uart_main_ctrl_tb

//--- uart_rx_error.sv
// ----------------------------------------------------------
// Receive error flags and sticky configuration error
// Parity result is valid only while rx_empty_i is low
// ----------------------------------------------------------

`timescale 1ns/1ps

module uart_rx_error import uart_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rx_empty_i,
  input  logic       rx_parity_i,
  input  logic       frame_error_i,
  input  logic       overrun_error_i,
  input  logic       cfg_fail_i,
  input  logic       irq_ack_i,
  input  uart_byte_t rx_data_i,
  input  cfg_field_t data_width_i,
  input  cfg_field_t parity_i,
  output logic       parity_error_o,
  output logic       frame_error_o,
  output logic       overrun_error_o,
  output logic       config_error_o
);

  logic data_xor;

  // ----------------------------------------------------------
  // Parity check on the FIFO head
  // ----------------------------------------------------------

  always_comb begin
    // XOR over the active data bits only
    case (data_width_i)
      2'b00:   data_xor = ^rx_data_i[4:0];
      2'b01:   data_xor = ^rx_data_i[5:0];
      2'b10:   data_xor = ^rx_data_i[6:0];
      default: data_xor = ^rx_data_i;
    endcase
    case (parity_i)
      2'b01:   parity_error_o = !rx_empty_i && (rx_parity_i != data_xor);
      2'b10:   parity_error_o = !rx_empty_i && (rx_parity_i != !data_xor);
      // No parity, nothing to flag
      default: parity_error_o = 1'b0;
    endcase
  end

  assign frame_error_o   = frame_error_i;
  assign overrun_error_o = overrun_error_i;

  // Sticky config error, set beats acknowledge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      config_error_o <= 1'b0;
    end else if (cfg_fail_i) begin
      config_error_o <= 1'b1;
    end else if (irq_ack_i) begin
      config_error_o <= 1'b0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(config_error_o) |-> $past(cfg_fail_i))
    else $error("Config error raised without a failure");

endmodule : uart_rx_error
